/* Makefile */
SIM      = verilator
FLAGS    = --binary --timing --assert
TOP      = tb_valu
FILELIST = project.f
OBJ_DIR  = obj_dir
PASS_MSG = TEST RESULT: PASS

.PHONY: all compile run clean

all: run

compile:
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP) 2>&1)"; echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

/* project.f */
valu_pkg.sv
valu_disp_pickup.sv
valu_issue_queue.sv
valu_vrf.sv
valu_pipe.sv
valu_top.sv
tb_valu.sv

/* tb_valu.sv */
// Vector ALU cluster testbench
`timescale 1ns/1ps
`default_nettype none

module tb_valu import valu_pkg::*; ();

  localparam int NTAG = 1 << TAG_W;

  logic             clk;
  logic             rst_n;
  logic             disp_valid;
  vec_inst_u        disp_inst;
  logic [TAG_W-1:0] disp_tag;
  logic             disp_ready;
  logic             done_valid;
  logic [TAG_W-1:0] done_tag;
  logic [REG_W-1:0] done_vd;
  logic [VLEN-1:0]  done_data;

  // Stimulus table
  logic [17:0] tbl_inst [$];
  string       tbl_name [$];

  // Reference state and expected results by tag
  logic [VLEN-1:0]  model_vrf [NREG];
  logic [REG_W-1:0] exp_vd    [NTAG];
  logic [VLEN-1:0]  exp_data  [NTAG];
  string            exp_name  [NTAG];
  int               sent_per_tag [NTAG] = '{default: 0};
  int               done_per_tag [NTAG] = '{default: 0};
  int               done_count = 0;
  int               cycle_cnt = 0;
  int               seed;

  valu_top dut (
    .i_clk        (clk),
    .i_rst_n      (rst_n),
    .i_disp_valid (disp_valid),
    .i_disp_inst  (disp_inst),
    .i_disp_tag   (disp_tag),
    .o_disp_ready (disp_ready),
    .o_done_valid (done_valid),
    .o_done_tag   (done_tag),
    .o_done_vd    (done_vd),
    .o_done_data  (done_data)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // --------------------------------------------------
  // Failure handling and checks
  // --------------------------------------------------
  task automatic fail_stop();
    $display("TEST RESULT: FAIL");
    $fatal(1, "Simulation stopped on error");
  endtask

  task automatic check(input string name, input logic [31:0] expected,
                       input logic [31:0] actual);
    if (expected !== actual) begin
      $display("Fail %s: expected %h, actual %h", name, expected, actual);
      fail_stop();
    end
  endtask

  // --------------------------------------------------
  // Instruction encoding and reference model
  // --------------------------------------------------
  function automatic logic [17:0] enc_vv(input op_e op, input logic [2:0] vd,
                                         input logic [2:0] vs2, input logic [2:0] vs1);
    return {op, 1'b0, vd, vs2, 5'b00000, vs1};
  endfunction

  function automatic logic [17:0] enc_vx(input op_e op, input logic [2:0] vd,
                                         input logic [2:0] vs2, input logic [7:0] sc);
    return {op, 1'b1, vd, vs2, sc};
  endfunction

  function automatic logic [7:0] rand_byte();
    return 8'($random(seed));
  endfunction

  // Lane result, wraps modulo 256
  function automatic logic [7:0] lane_ref(input op_e op, input logic [7:0] x,
                                          input logic [7:0] y);
    int r;
    r = 0;
    case (op)
      OP_ADD:  r = (int'(x) + int'(y)) % 256;
      OP_SUB:  r = (int'(x) - int'(y) + 256) % 256;
      OP_AND:  r = int'(x & y);
      OP_OR:   r = int'(x | y);
      OP_XOR:  r = int'(x ^ y);
      OP_MINU: r = (x < y) ? int'(x) : int'(y);
      OP_MAXU: r = (x > y) ? int'(x) : int'(y);
      OP_MV:   r = int'(y);
    endcase
    return 8'(r);
  endfunction

  task automatic model_apply(input logic [17:0] inst, output logic [2:0] vd,
                             output logic [31:0] data);
    op_e         op;
    logic [31:0] a;
    logic [31:0] b;
    op = op_e'(inst[17:15]);
    vd = inst[13:11];
    a  = model_vrf[inst[10:8]];
    // Scalar form broadcasts the low byte
    b  = inst[14] ? {4{inst[7:0]}} : model_vrf[inst[2:0]];
    for (int l = 0; l < LANES; l++) begin
      data[l*ELEM_W +: ELEM_W] = lane_ref(op, a[l*ELEM_W +: ELEM_W], b[l*ELEM_W +: ELEM_W]);
    end
    model_vrf[vd] = data;
  endtask

  task automatic add_entry(input logic [17:0] inst, input string name);
    tbl_inst.push_back(inst);
    tbl_name.push_back(name);
  endtask

  task automatic build_table();
    logic [7:0] s;
    op_e        op;
    add_entry(enc_vv(OP_MV, 3'd1, 3'd0, 3'd0), "reset_mv_zero");
    for (int r = 0; r < NREG; r++) begin
      s = rand_byte();
      add_entry(enc_vx(OP_MV, REG_W'(r), 3'd0, s), $sformatf("vx_mv_v%0d", r));
    end
    for (int k = 0; k < 7; k++) begin
      op = op_e'(k);
      s  = rand_byte();
      add_entry(enc_vx(op, REG_W'(k), REG_W'((k + 3) % NREG), s),
                $sformatf("vx_%s", op.name()));
    end
    // Lane wraparound
    add_entry(enc_vx(OP_MV, 3'd6, 3'd0, 8'hff), "wrap_mv_ff");
    add_entry(enc_vx(OP_ADD, 3'd7, 3'd6, 8'h01), "wrap_add_ff_1");
    add_entry(enc_vx(OP_MV, 3'd5, 3'd0, 8'h00), "wrap_mv_00");
    add_entry(enc_vx(OP_SUB, 3'd4, 3'd5, 8'h01), "wrap_sub_0_1");
    // Vector-vector forms, both operand orders for min and max
    add_entry(enc_vx(OP_MV, 3'd1, 3'd0, 8'h3c), "vv_load_v1");
    add_entry(enc_vx(OP_MV, 3'd2, 3'd0, 8'ha5), "vv_load_v2");
    for (int k = 0; k < 5; k++) begin
      op = op_e'(k);
      add_entry(enc_vv(op, REG_W'(3 + k), 3'd1, 3'd2), $sformatf("vv_%s", op.name()));
    end
    add_entry(enc_vv(OP_MINU, 3'd3, 3'd1, 3'd2), "vv_minu_lo_hi");
    add_entry(enc_vv(OP_MINU, 3'd4, 3'd2, 3'd1), "vv_minu_hi_lo");
    add_entry(enc_vv(OP_MAXU, 3'd5, 3'd1, 3'd2), "vv_maxu_lo_hi");
    add_entry(enc_vv(OP_MAXU, 3'd6, 3'd2, 3'd1), "vv_maxu_hi_lo");
    add_entry(enc_vv(OP_MV, 3'd7, 3'd0, 3'd2), "vv_mv");
    // Dependency chain on v1 and v2
    add_entry(enc_vx(OP_MV, 3'd1, 3'd0, rand_byte()), "dep_mv_v1");
    add_entry(enc_vv(OP_ADD, 3'd2, 3'd1, 3'd1), "dep_raw_add");
    add_entry(enc_vx(OP_MV, 3'd1, 3'd0, rand_byte()), "dep_waw_war_mv");
    add_entry(enc_vv(OP_SUB, 3'd1, 3'd1, 3'd2), "dep_raw_sub");
    add_entry(enc_vx(OP_OR, 3'd2, 3'd1, rand_byte()), "dep_war_or");
    // Burst that fills the queue, then an accumulate chain
    add_entry(enc_vx(OP_MV, 3'd1, 3'd0, rand_byte()), "burst_mv_v1");
    for (int j = 2; j < NREG; j++) begin
      add_entry(enc_vx(OP_ADD, REG_W'(j), 3'd1, rand_byte()), $sformatf("burst_fan_v%0d", j));
    end
    for (int j = 0; j < 4; j++) begin
      add_entry(enc_vx(OP_XOR, 3'd3, 3'd3, rand_byte()), $sformatf("burst_acc_%0d", j));
    end
  endtask

  // --------------------------------------------------
  // Dispatch, called on a falling edge
  // --------------------------------------------------
  task automatic send(input logic [17:0] inst, input logic [TAG_W-1:0] tag);
    disp_valid = 1'b1;
    disp_inst  = inst;
    disp_tag   = tag;
    #1;
    while (!disp_ready) begin
      @(negedge clk);
      #1;
    end
    @(negedge clk);
  endtask

  // Done report monitor
  always @(negedge clk) begin
    if (rst_n && done_valid) begin
      if (done_per_tag[done_tag] >= sent_per_tag[done_tag]) begin
        $display("Done report for tag %0d with no outstanding instruction", done_tag);
        fail_stop();
      end else begin
        check($sformatf("%s vd", exp_name[done_tag]), 32'(exp_vd[done_tag]), 32'(done_vd));
        check(exp_name[done_tag], exp_data[done_tag], done_data);
        done_per_tag[done_tag]++;
        done_count++;
      end
    end
  end

  // Run limit scales with the table length
  initial begin
    while (cycle_cnt < 40 * tbl_inst.size() + 100) begin
      @(posedge clk);
      cycle_cnt++;
    end
    $display("Timeout after %0d cycles with %0d of %0d instructions done",
             cycle_cnt, done_count, tbl_inst.size());
    fail_stop();
  end

  initial begin
    logic [TAG_W-1:0] tag;
    logic [2:0]       vd;
    logic [31:0]      data;
    seed       = 32'hb34a8be7;
    rst_n      = 1'b0;
    disp_valid = 1'b0;
    disp_inst  = '0;
    disp_tag   = '0;
    for (int r = 0; r < NREG; r++) begin
      model_vrf[r] = '0;
    end
    build_table();
    repeat (2) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    @(negedge clk);
    check("reset_done_valid", 32'd0, 32'(done_valid));
    check("reset_disp_ready", 32'd1, 32'(disp_ready));

    for (int i = 0; i < tbl_inst.size(); i++) begin
      tag = TAG_W'(i);
      // Tag still in flight from an earlier entry
      if (done_per_tag[tag] != sent_per_tag[tag]) begin
        disp_valid = 1'b0;
        while (done_per_tag[tag] != sent_per_tag[tag]) begin
          @(negedge clk);
        end
      end
      model_apply(tbl_inst[i], vd, data);
      exp_vd[tag]   = vd;
      exp_data[tag] = data;
      exp_name[tag] = tbl_name[i];
      sent_per_tag[tag]++;
      send(tbl_inst[i], tag);
    end
    disp_valid = 1'b0;

    while (done_count < tbl_inst.size()) begin
      @(negedge clk);
    end
    // Idle window for stray reports
    repeat (8) @(negedge clk);
    if (done_count == tbl_inst.size()) begin
      $display("TEST RESULT: PASS");
      $finish;
    end else begin
      $display("Got %0d done reports for %0d instructions", done_count, tbl_inst.size());
      fail_stop();
    end
  end

endmodule

`default_nettype wire

/* valu_disp_pickup.sv */
// Dispatch pickup with skid register
`timescale 1ns/1ps
`default_nettype none

module valu_disp_pickup import valu_pkg::*; (
  input  wire logic              i_clk,
  input  wire logic              i_rst_n,

  input  wire logic              i_disp_valid,
  input  wire vec_inst_u         i_disp_inst,
  input  wire logic [TAG_W-1:0]  i_disp_tag,
  output logic                   o_disp_ready,

  output logic                   o_pk_valid,
  input  wire logic              i_pk_ready,
  output op_e                    o_pk_op,
  output logic [REG_W-1:0]       o_pk_vd,
  output logic [REG_W-1:0]       o_pk_vs2,
  output logic [REG_W-1:0]       o_pk_vs1,
  output logic [ELEM_W-1:0]      o_pk_scalar,
  output logic                   o_pk_is_scalar,
  output logic [TAG_W-1:0]       o_pk_tag
);

  logic             skid_valid;
  vec_inst_u        skid_inst;
  logic [TAG_W-1:0] skid_tag;
  vec_inst_u        sel_inst;
  logic             skid_load;

  assign o_disp_ready = !skid_valid || i_pk_ready;

  // Capture when the queue refuses, or when the held entry drains under a new one
  assign skid_load = i_disp_valid && o_disp_ready && (skid_valid || !i_pk_ready);

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      skid_valid <= 1'b0;
    end else if (skid_load) begin
      skid_valid <= 1'b1;
    end else if (i_pk_ready) begin
      skid_valid <= 1'b0;
    end
  end

  always_ff @(posedge i_clk) begin
    if (skid_load) begin
      skid_inst <= i_disp_inst;
      skid_tag  <= i_disp_tag;
    end
  end

  // --------------------------------------------------
  // Decode with the held entry first since it is older
  // --------------------------------------------------
  assign sel_inst       = skid_valid ? skid_inst : i_disp_inst;
  assign o_pk_valid     = skid_valid || i_disp_valid;
  assign o_pk_tag       = skid_valid ? skid_tag : i_disp_tag;

  assign o_pk_is_scalar = sel_inst.vx.fmt;
  assign o_pk_op        = sel_inst.vv.op;
  assign o_pk_vd        = sel_inst.vv.vd;
  assign o_pk_vs2       = sel_inst.vv.vs2;
  // Low byte read as register index or as scalar
  assign o_pk_vs1       = sel_inst.vv.vs1;
  assign o_pk_scalar    = sel_inst.vx.scalar;

endmodule

`default_nettype wire

/* valu_issue_queue.sv */
// Vector issue queue
`timescale 1ns/1ps
`default_nettype none

module valu_issue_queue import valu_pkg::*; (
  input  wire logic              i_clk,
  input  wire logic              i_rst_n,

  input  wire logic              i_pk_valid,
  input  wire op_e               i_pk_op,
  input  wire logic [REG_W-1:0]  i_pk_vd,
  input  wire logic [REG_W-1:0]  i_pk_vs2,
  input  wire logic [REG_W-1:0]  i_pk_vs1,
  input  wire logic [ELEM_W-1:0] i_pk_scalar,
  input  wire logic              i_pk_is_scalar,
  input  wire logic [TAG_W-1:0]  i_pk_tag,
  output logic                   o_pk_ready,

  input  wire logic              i_wb_valid,
  input  wire logic [REG_W-1:0]  i_wb_vd,

  output logic                   o_iss_valid,
  output op_e                    o_iss_op,
  output logic [REG_W-1:0]       o_iss_vd,
  output logic [REG_W-1:0]       o_iss_vs2,
  output logic [REG_W-1:0]       o_iss_vs1,
  output logic [ELEM_W-1:0]      o_iss_scalar,
  output logic                   o_iss_is_scalar,
  output logic [TAG_W-1:0]       o_iss_tag
);

  // Entry 0 is the oldest and the queue stays compacted
  logic [QDEPTH-1:0] q_valid;
  op_e               q_op     [QDEPTH];
  logic [REG_W-1:0]  q_vd     [QDEPTH];
  logic [REG_W-1:0]  q_vs2    [QDEPTH];
  logic [REG_W-1:0]  q_vs1    [QDEPTH];
  logic [ELEM_W-1:0] q_scalar [QDEPTH];
  logic [QDEPTH-1:0] q_is_scalar;
  logic [TAG_W-1:0]  q_tag    [QDEPTH];

  logic [NREG-1:0]   busy;
  logic [QDEPTH-1:0] use_vs2;
  logic [QDEPTH-1:0] use_vs1;
  logic [QDEPTH-1:0] q_rdy;
  logic [CNT_W-1:0]  cnt;
  logic [CNT_W-1:0]  cnt_nxt;
  logic [CNT_W-1:0]  wr_slot;
  logic [IDX_W-1:0]  iss_idx;
  logic              war_hit;
  logic              pk_fire;
  logic              older_wr_hit;

  // --------------------------------------------------
  // Readiness, hazards and oldest-ready select
  // --------------------------------------------------
  always_comb begin
    war_hit = 1'b0;
    iss_idx = '0;
    o_iss_valid = 1'b0;
    for (int i = 0; i < QDEPTH; i++) begin
      use_vs2[i] = q_op[i] != OP_MV;
      use_vs1[i] = !q_is_scalar[i];
      // A source equal to its own vd only sees the entry's own busy bit
      q_rdy[i] = q_valid[i] &&
                 !(use_vs2[i] && busy[q_vs2[i]] && q_vs2[i] != q_vd[i]) &&
                 !(use_vs1[i] && busy[q_vs1[i]] && q_vs1[i] != q_vd[i]);
      if (q_valid[i] && ((use_vs2[i] && q_vs2[i] == i_pk_vd) ||
                         (use_vs1[i] && q_vs1[i] == i_pk_vd))) begin
        war_hit = 1'b1;
      end
    end
    for (int i = QDEPTH - 1; i >= 0; i--) begin
      if (q_rdy[i]) begin
        o_iss_valid = 1'b1;
        iss_idx     = IDX_W'(i);
      end
    end
  end

  assign cnt        = CNT_W'($countones(q_valid));
  assign o_pk_ready = (cnt != CNT_W'(QDEPTH)) && !busy[i_pk_vd] && !war_hit;
  assign pk_fire    = i_pk_valid && o_pk_ready;
  assign wr_slot    = cnt - CNT_W'(o_iss_valid);
  assign cnt_nxt    = wr_slot + CNT_W'(pk_fire);

  assign o_iss_op        = q_op[iss_idx];
  assign o_iss_vd        = q_vd[iss_idx];
  assign o_iss_vs2       = q_vs2[iss_idx];
  assign o_iss_vs1       = q_vs1[iss_idx];
  assign o_iss_scalar    = q_scalar[iss_idx];
  assign o_iss_is_scalar = q_is_scalar[iss_idx];
  assign o_iss_tag       = q_tag[iss_idx];

  // --------------------------------------------------
  // Occupancy and busy scoreboard
  // --------------------------------------------------
  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      q_valid <= '0;
      busy    <= '0;
    end else begin
      for (int i = 0; i < QDEPTH; i++) begin
        q_valid[i] <= i < int'(cnt_nxt);
      end
      if (i_wb_valid) begin
        busy[i_wb_vd] <= 1'b0;
      end
      if (pk_fire) begin
        busy[i_pk_vd] <= 1'b1;
      end
    end
  end

  // Collapse over the issued slot and append at the tail
  always_ff @(posedge i_clk) begin
    for (int i = 0; i < QDEPTH; i++) begin
      int src;
      src = (i < QDEPTH - 1) ? i + 1 : i;
      if (pk_fire && int'(wr_slot) == i) begin
        q_op[i]        <= i_pk_op;
        q_vd[i]        <= i_pk_vd;
        q_vs2[i]       <= i_pk_vs2;
        q_vs1[i]       <= i_pk_vs1;
        q_scalar[i]    <= i_pk_scalar;
        q_is_scalar[i] <= i_pk_is_scalar;
        q_tag[i]       <= i_pk_tag;
      end else if (o_iss_valid && i >= int'(iss_idx)) begin
        q_op[i]        <= q_op[src];
        q_vd[i]        <= q_vd[src];
        q_vs2[i]       <= q_vs2[src];
        q_vs1[i]       <= q_vs1[src];
        q_scalar[i]    <= q_scalar[src];
        q_is_scalar[i] <= q_is_scalar[src];
        q_tag[i]       <= q_tag[src];
      end
    end
  end

  // Issued sources against writers still queued ahead of it
  always_comb begin
    older_wr_hit = 1'b0;
    for (int j = 0; j < QDEPTH; j++) begin
      if (q_valid[j] && j < int'(iss_idx) &&
          ((o_iss_op != OP_MV && q_vd[j] == o_iss_vs2) ||
           (!o_iss_is_scalar && q_vd[j] == o_iss_vs1))) begin
        older_wr_hit = 1'b1;
      end
    end
  end

  // Nothing issues ahead of an older queued write to one of its sources
  a_iss_src_free: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    o_iss_valid |-> !older_wr_hit);

  // Each writeback clears a bit that its own accept set
  a_busy_single: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    i_wb_valid |-> busy[i_wb_vd]);

endmodule

`default_nettype wire

/* valu_pipe.sv */
// Three-stage vector ALU pipe
`timescale 1ns/1ps
`default_nettype none

module valu_pipe import valu_pkg::*; (
  input  wire logic              i_clk,
  input  wire logic              i_rst_n,

  input  wire logic              i_iss_valid,
  input  wire op_e               i_iss_op,
  input  wire logic [REG_W-1:0]  i_iss_vd,
  input  wire logic [REG_W-1:0]  i_iss_vs2,
  input  wire logic [REG_W-1:0]  i_iss_vs1,
  input  wire logic [ELEM_W-1:0] i_iss_scalar,
  input  wire logic              i_iss_is_scalar,
  input  wire logic [TAG_W-1:0]  i_iss_tag,

  output logic [REG_W-1:0]       o_rd0_idx,
  input  wire logic [VLEN-1:0]   i_rd0_data,
  output logic [REG_W-1:0]       o_rd1_idx,
  input  wire logic [VLEN-1:0]   i_rd1_data,

  output logic                   o_wr_en,
  output logic [REG_W-1:0]       o_wr_idx,
  output logic [VLEN-1:0]        o_wr_data,

  output logic                   o_done_valid,
  output logic [TAG_W-1:0]       o_done_tag,
  output logic [REG_W-1:0]       o_done_vd,
  output logic [VLEN-1:0]        o_done_data
);

  logic              ex1_valid;
  op_e               ex1_op;
  logic [REG_W-1:0]  ex1_vd;
  logic [REG_W-1:0]  ex1_vs2;
  logic [REG_W-1:0]  ex1_vs1;
  logic [ELEM_W-1:0] ex1_scalar;
  logic              ex1_is_scalar;
  logic [TAG_W-1:0]  ex1_tag;
  logic [VLEN-1:0]   ex1_opb;

  logic              ex2_valid;
  op_e               ex2_op;
  logic [REG_W-1:0]  ex2_vd;
  logic [TAG_W-1:0]  ex2_tag;
  logic [VLEN-1:0]   ex2_opa;
  logic [VLEN-1:0]   ex2_opb;
  logic [VLEN-1:0]   ex2_res;

  logic              ex3_valid;
  logic [REG_W-1:0]  ex3_vd;
  logic [TAG_W-1:0]  ex3_tag;
  logic [VLEN-1:0]   ex3_res;

  // One lane that wraps modulo 256
  function automatic logic [ELEM_W-1:0] lane_alu(input op_e op,
                                                 input logic [ELEM_W-1:0] a,
                                                 input logic [ELEM_W-1:0] b);
    case (op)
      OP_ADD:  return a + b;
      OP_SUB:  return a - b;
      OP_AND:  return a & b;
      OP_OR:   return a | b;
      OP_XOR:  return a ^ b;
      OP_MINU: return (a < b) ? a : b;
      OP_MAXU: return (a > b) ? a : b;
      default: return b;
    endcase
  endfunction

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      ex1_valid <= 1'b0;
      ex2_valid <= 1'b0;
      ex3_valid <= 1'b0;
    end else begin
      ex1_valid <= i_iss_valid;
      ex2_valid <= ex1_valid;
      ex3_valid <= ex2_valid;
    end
  end

  // --------------------------------------------------
  // ex1 operand read
  // --------------------------------------------------
  always_ff @(posedge i_clk) begin
    ex1_op        <= i_iss_op;
    ex1_vd        <= i_iss_vd;
    ex1_vs2       <= i_iss_vs2;
    ex1_vs1       <= i_iss_vs1;
    ex1_scalar    <= i_iss_scalar;
    ex1_is_scalar <= i_iss_is_scalar;
    ex1_tag       <= i_iss_tag;
  end

  assign o_rd0_idx = ex1_vs2;
  assign o_rd1_idx = ex1_vs1;
  // Scalar broadcast to every lane
  assign ex1_opb   = ex1_is_scalar ? {LANES{ex1_scalar}} : i_rd1_data;

  // --------------------------------------------------
  // ex2 lane compute
  // --------------------------------------------------
  always_ff @(posedge i_clk) begin
    ex2_op  <= ex1_op;
    ex2_vd  <= ex1_vd;
    ex2_tag <= ex1_tag;
    ex2_opa <= i_rd0_data;
    ex2_opb <= ex1_opb;
  end

  always_comb begin
    for (int l = 0; l < LANES; l++) begin
      ex2_res[l*ELEM_W +: ELEM_W] = lane_alu(ex2_op, ex2_opa[l*ELEM_W +: ELEM_W],
                                             ex2_opb[l*ELEM_W +: ELEM_W]);
    end
  end

  // --------------------------------------------------
  // ex3 writeback and done
  // --------------------------------------------------
  always_ff @(posedge i_clk) begin
    ex3_vd  <= ex2_vd;
    ex3_tag <= ex2_tag;
    ex3_res <= ex2_res;
  end

  assign o_wr_en      = ex3_valid;
  assign o_wr_idx     = ex3_vd;
  assign o_wr_data    = ex3_res;
  assign o_done_valid = ex3_valid;
  assign o_done_tag   = ex3_tag;
  assign o_done_vd    = ex3_vd;
  assign o_done_data  = ex3_res;

  // Tag and vd of an issue reach done a fixed three cycles later
  a_done_latency: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    i_iss_valid |-> ##3 (o_done_valid && o_done_tag == $past(i_iss_tag, 3) &&
                         o_done_vd == $past(i_iss_vd, 3)));

endmodule

`default_nettype wire

/* valu_pkg.sv */
// Vector ALU cluster definitions
`default_nettype none

package valu_pkg;

  // --------------------------------------------------
  // Vector and register file sizes
  // --------------------------------------------------
  localparam int LANES  = 4;
  localparam int ELEM_W = 8;
  localparam int VLEN   = LANES * ELEM_W;
  localparam int NREG   = 8;
  localparam int REG_W  = 3;
  localparam int TAG_W  = 4;

  // Issue queue sizing
  localparam int QDEPTH = 4;
  localparam int IDX_W  = $clog2(QDEPTH);
  localparam int CNT_W  = $clog2(QDEPTH + 1);

  // --------------------------------------------------
  // Operation codes
  // --------------------------------------------------
  typedef enum logic [2:0] {
    OP_ADD  = 3'd0,
    OP_SUB  = 3'd1,
    OP_AND  = 3'd2,
    OP_OR   = 3'd3,
    OP_XOR  = 3'd4,
    OP_MINU = 3'd5,
    OP_MAXU = 3'd6,
    OP_MV   = 3'd7
  } op_e;

  // --------------------------------------------------
  // Instruction word, two views of the low byte
  // --------------------------------------------------
  // Vector-vector form, fmt = 0
  typedef struct packed {
    op_e              op;
    logic             fmt;
    logic [REG_W-1:0] vd;
    logic [REG_W-1:0] vs2;
    logic [4:0]       rsvd;
    logic [REG_W-1:0] vs1;
  } vv_inst_t;

  // Vector-scalar form, fmt = 1
  typedef struct packed {
    op_e               op;
    logic              fmt;
    logic [REG_W-1:0]  vd;
    logic [REG_W-1:0]  vs2;
    logic [ELEM_W-1:0] scalar;
  } vx_inst_t;

  typedef union packed {
    vv_inst_t vv;
    vx_inst_t vx;
  } vec_inst_u;

endpackage

`default_nettype wire

/* valu_top.sv */
// Vector ALU cluster top
`timescale 1ns/1ps
`default_nettype none

module valu_top import valu_pkg::*; (
  input  wire logic             i_clk,
  input  wire logic             i_rst_n,

  input  wire logic             i_disp_valid,
  input  wire vec_inst_u        i_disp_inst,
  input  wire logic [TAG_W-1:0] i_disp_tag,
  output logic                  o_disp_ready,

  output logic                  o_done_valid,
  output logic [TAG_W-1:0]      o_done_tag,
  output logic [REG_W-1:0]      o_done_vd,
  output logic [VLEN-1:0]       o_done_data
);

  // Pickup to queue
  logic              pk_valid;
  logic              pk_ready;
  op_e               pk_op;
  logic [REG_W-1:0]  pk_vd;
  logic [REG_W-1:0]  pk_vs2;
  logic [REG_W-1:0]  pk_vs1;
  logic [ELEM_W-1:0] pk_scalar;
  logic              pk_is_scalar;
  logic [TAG_W-1:0]  pk_tag;

  // Queue to pipe
  logic              iss_valid;
  op_e               iss_op;
  logic [REG_W-1:0]  iss_vd;
  logic [REG_W-1:0]  iss_vs2;
  logic [REG_W-1:0]  iss_vs1;
  logic [ELEM_W-1:0] iss_scalar;
  logic              iss_is_scalar;
  logic [TAG_W-1:0]  iss_tag;

  // Register file ports whose write side doubles as writeback to the queue
  logic [REG_W-1:0]  rd0_idx;
  logic [VLEN-1:0]   rd0_data;
  logic [REG_W-1:0]  rd1_idx;
  logic [VLEN-1:0]   rd1_data;
  logic              wr_en;
  logic [REG_W-1:0]  wr_idx;
  logic [VLEN-1:0]   wr_data;

  valu_disp_pickup u_pickup (
    .i_clk          (i_clk),
    .i_rst_n        (i_rst_n),
    .i_disp_valid   (i_disp_valid),
    .i_disp_inst    (i_disp_inst),
    .i_disp_tag     (i_disp_tag),
    .o_disp_ready   (o_disp_ready),
    .o_pk_valid     (pk_valid),
    .i_pk_ready     (pk_ready),
    .o_pk_op        (pk_op),
    .o_pk_vd        (pk_vd),
    .o_pk_vs2       (pk_vs2),
    .o_pk_vs1       (pk_vs1),
    .o_pk_scalar    (pk_scalar),
    .o_pk_is_scalar (pk_is_scalar),
    .o_pk_tag       (pk_tag)
  );

  valu_issue_queue u_queue (
    .i_clk           (i_clk),
    .i_rst_n         (i_rst_n),
    .i_pk_valid      (pk_valid),
    .i_pk_op         (pk_op),
    .i_pk_vd         (pk_vd),
    .i_pk_vs2        (pk_vs2),
    .i_pk_vs1        (pk_vs1),
    .i_pk_scalar     (pk_scalar),
    .i_pk_is_scalar  (pk_is_scalar),
    .i_pk_tag        (pk_tag),
    .o_pk_ready      (pk_ready),
    .i_wb_valid      (wr_en),
    .i_wb_vd         (wr_idx),
    .o_iss_valid     (iss_valid),
    .o_iss_op        (iss_op),
    .o_iss_vd        (iss_vd),
    .o_iss_vs2       (iss_vs2),
    .o_iss_vs1       (iss_vs1),
    .o_iss_scalar    (iss_scalar),
    .o_iss_is_scalar (iss_is_scalar),
    .o_iss_tag       (iss_tag)
  );

  valu_pipe u_pipe (
    .i_clk           (i_clk),
    .i_rst_n         (i_rst_n),
    .i_iss_valid     (iss_valid),
    .i_iss_op        (iss_op),
    .i_iss_vd        (iss_vd),
    .i_iss_vs2       (iss_vs2),
    .i_iss_vs1       (iss_vs1),
    .i_iss_scalar    (iss_scalar),
    .i_iss_is_scalar (iss_is_scalar),
    .i_iss_tag       (iss_tag),
    .o_rd0_idx       (rd0_idx),
    .i_rd0_data      (rd0_data),
    .o_rd1_idx       (rd1_idx),
    .i_rd1_data      (rd1_data),
    .o_wr_en         (wr_en),
    .o_wr_idx        (wr_idx),
    .o_wr_data       (wr_data),
    .o_done_valid    (o_done_valid),
    .o_done_tag      (o_done_tag),
    .o_done_vd       (o_done_vd),
    .o_done_data     (o_done_data)
  );

  valu_vrf u_vrf (
    .i_clk      (i_clk),
    .i_rst_n    (i_rst_n),
    .i_rd0_idx  (rd0_idx),
    .o_rd0_data (rd0_data),
    .i_rd1_idx  (rd1_idx),
    .o_rd1_data (rd1_data),
    .i_wr_en    (wr_en),
    .i_wr_idx   (wr_idx),
    .i_wr_data  (wr_data)
  );

endmodule

`default_nettype wire

/* valu_vrf.sv */
// Vector register file
`timescale 1ns/1ps
`default_nettype none

module valu_vrf import valu_pkg::*; (
  input  wire logic             i_clk,
  input  wire logic             i_rst_n,

  input  wire logic [REG_W-1:0] i_rd0_idx,
  output logic [VLEN-1:0]       o_rd0_data,
  input  wire logic [REG_W-1:0] i_rd1_idx,
  output logic [VLEN-1:0]       o_rd1_data,

  input  wire logic             i_wr_en,
  input  wire logic [REG_W-1:0] i_wr_idx,
  input  wire logic [VLEN-1:0]  i_wr_data
);

  logic [VLEN-1:0] regs [NREG];

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      for (int i = 0; i < NREG; i++) begin
        regs[i] <= '0;
      end
    end else if (i_wr_en) begin
      regs[i_wr_idx] <= i_wr_data;
    end
  end

  // --------------------------------------------------
  // Read ports with write-through
  // --------------------------------------------------
  assign o_rd0_data = (i_wr_en && i_wr_idx == i_rd0_idx) ? i_wr_data : regs[i_rd0_idx];
  assign o_rd1_data = (i_wr_en && i_wr_idx == i_rd1_idx) ? i_wr_data : regs[i_rd1_idx];

endmodule

`default_nettype wire
